//--- Bender.yml
package:
  name: instruction_cache

sources:
  # packages first, then the stages and the top level
  - hdl/CachePkg.sv
  - hdl/FetchPkg.sv
  - hdl/TagLookup.sv
  - hdl/CacheMemory.sv
  - hdl/InstructionAlign.sv
  - hdl/InstructionCache.sv

  # testbench, top module InstructionCacheTb
  - target: test
    files:
      - sim/InstructionCache_assert.sv
      - sim/InstructionCacheTb.sv

//--- InstructionCache.f
hdl/CachePkg.sv
hdl/FetchPkg.sv
hdl/TagLookup.sv
hdl/CacheMemory.sv
hdl/InstructionAlign.sv
hdl/InstructionCache.sv
sim/InstructionCache_assert.sv
sim/InstructionCacheTb.sv

//--- hdl/CacheMemory.sv
`timescale 1ns/1ps

module CacheMemory
(
	input  logic               clock_i,
	input  logic               rstN_i,
	input  logic               flush_i,
	// lookup from the tag stage
	input  logic               fetchEnable_i,
	input  CachePkg::tag_t     tag_i,
	input  CachePkg::index_t   index_i,
	input  CachePkg::offset_t  offset_i,
	// line update
	input  logic               updateEnable_i,
	input  logic               updateDeliver_i,
	input  CachePkg::line_t    newLine_i,
	input  CachePkg::tag_t     newTag_i,
	input  CachePkg::index_t   newIndex_i,
	input  CachePkg::offset_t  newOffset_i,
	// towards the aligner
	output CachePkg::tag_t     tag_o,
	output CachePkg::index_t   index_o,
	output CachePkg::offset_t  offset_o,
	output CachePkg::line_t    cacheline_o,
	output logic               enable_o
);

	// line store, one port
	CachePkg::line_t dataArray [CachePkg::numLines];

	// single address: update index when writing, lookup index otherwise
	CachePkg::index_t memAddr;

	// address and bypass stage
	CachePkg::index_t readAddr;
	logic bypassEnable;
	logic bypassDeliver;
	CachePkg::tag_t bypassTag;
	CachePkg::index_t bypassIndex;
	CachePkg::offset_t bypassOffset;
	CachePkg::line_t bypassLine;

	assign memAddr = updateEnable_i ? newIndex_i : index_i;

	////////////////////////////////////////////////////////////////////////////
	// write port
	////////////////////////////////////////////////////////////////////////////

	// writes take one cycle and are not stopped by a flush
	always_ff @(posedge clock_i)
	begin
		if (updateEnable_i)
			dataArray[memAddr] <= newLine_i;
	end

	////////////////////////////////////////////////////////////////////////////
	// read pipeline control
	////////////////////////////////////////////////////////////////////////////

	always_ff @(posedge clock_i or negedge rstN_i)
	begin
		if (!rstN_i)
		begin
			bypassEnable  <= 1'b0;
			bypassDeliver <= 1'b0;
			enable_o      <= 1'b0;
		end
		else if (flush_i)
		begin
			bypassEnable  <= 1'b0;
			bypassDeliver <= 1'b0;
			enable_o      <= 1'b0;
		end
		else
		begin
			// stage 1: a lookup read or a delivered update
			bypassEnable  <= fetchEnable_i;
			bypassDeliver <= updateDeliver_i;
			// stage 2: one valid beat towards the aligner
			enable_o      <= bypassEnable || bypassDeliver;
		end
	end

	////////////////////////////////////////////////////////////////////////////
	// read pipeline payload
	////////////////////////////////////////////////////////////////////////////

	always_ff @(posedge clock_i)
	begin
		// stage 1 captures the address and the request fields
		readAddr <= memAddr;
		if (updateDeliver_i)
		begin
			bypassTag    <= newTag_i;
			bypassIndex  <= newIndex_i;
			bypassOffset <= newOffset_i;
			// refill line goes straight on, no array read needed
			bypassLine   <= newLine_i;
		end
		else
		begin
			bypassTag    <= tag_i;
			bypassIndex  <= index_i;
			bypassOffset <= offset_i;
		end

		// stage 2 registers the line, from the array or the bypass
		tag_o    <= bypassTag;
		index_o  <= bypassIndex;
		offset_o <= bypassOffset;
		if (bypassDeliver)
			cacheline_o <= bypassLine;
		else
			cacheline_o <= dataArray[readAddr];
	end

endmodule

//--- hdl/CachePkg.sv
package CachePkg;

	////////////////////////////////////////////////////////////////////////////
	// cache geometry
	////////////////////////////////////////////////////////////////////////////

	// fetch addresses are plain 32-bit byte addresses
	localparam int addrWidth = 32;

	// 32-byte lines
	localparam int offsetWidth = 5;

	// 16 lines, direct mapped
	localparam int indexWidth = 4;

	// everything above index and offset is tag
	localparam int tagWidth = addrWidth - indexWidth - offsetWidth;

	localparam int lineBits = 8 * (2 ** offsetWidth);
	localparam int numLines = 2 ** indexWidth;

	// one instruction word
	localparam int instrWidth = 32;

	////////////////////////////////////////////////////////////////////////////
	// vector types
	////////////////////////////////////////////////////////////////////////////

	typedef logic [addrWidth-1:0]   addr_t;
	typedef logic [tagWidth-1:0]    tag_t;
	typedef logic [indexWidth-1:0]  index_t;
	typedef logic [offsetWidth-1:0] offset_t;
	typedef logic [lineBits-1:0]    line_t;
	typedef logic [instrWidth-1:0]  instr_t;

endpackage

//--- hdl/FetchPkg.sv
package FetchPkg;

	// lookup stage FSM
	// LOOKUP accepts fetches, MISS_WAIT holds off fetches until the refill shows up
	typedef enum logic [0:0]
	{
		LOOKUP    = 1'b0,
		MISS_WAIT = 1'b1
	} lookupState_t;

	////////////////////////////////////////////////////////////////////////////
	// word select within a line
	////////////////////////////////////////////////////////////////////////////

	// eight 32-bit words per line
	localparam int wordSelWidth = 3;

	// the two byte-select bits under the word select
	localparam int wordSelLsb = 2;

endpackage

//--- hdl/InstructionAlign.sv
`timescale 1ns/1ps

module InstructionAlign
(
	input  logic               clock_i,
	input  logic               rstN_i,
	input  logic               flush_i,
	input  logic               enable_i,
	input  CachePkg::tag_t     tag_i,
	input  CachePkg::index_t   index_i,
	input  CachePkg::offset_t  offset_i,
	input  CachePkg::line_t    cacheline_i,
	output logic               instrValid_o,
	output CachePkg::instr_t   instr_o,
	output CachePkg::addr_t    pc_o
);

	// which of the eight words in the line
	logic [FetchPkg::wordSelWidth-1:0] wordSel;
	CachePkg::instr_t word;
	CachePkg::addr_t alignedPc;

	assign wordSel = offset_i[FetchPkg::wordSelLsb +: FetchPkg::wordSelWidth];

	// little endian, word w at bits 32w and up
	assign word = cacheline_i[wordSel * CachePkg::instrWidth +: CachePkg::instrWidth];

	// rebuild the PC with the byte bits cleared
	assign alignedPc = {tag_i, index_i, wordSel, {FetchPkg::wordSelLsb{1'b0}}};

	always_ff @(posedge clock_i or negedge rstN_i)
	begin
		if (!rstN_i)
			instrValid_o <= 1'b0;
		else
			instrValid_o <= enable_i && !flush_i;
	end

	// payload follows the valid beat only
	always_ff @(posedge clock_i)
	begin
		if (enable_i)
		begin
			instr_o <= word;
			pc_o    <= alignedPc;
		end
	end

endmodule

//--- hdl/InstructionCache.sv
`timescale 1ns/1ps

module InstructionCache
(
	input  logic               clock_i,
	input  logic               rstN_i,
	input  logic               flush_i,
	// fetch
	input  logic               fetchValid_i,
	input  CachePkg::addr_t    fetchAddr_i,
	output logic               fetchReady_o,
	// refill
	input  logic               refillValid_i,
	input  CachePkg::addr_t    refillAddr_i,
	input  CachePkg::line_t    refillLine_i,
	// miss report
	output logic               missValid_o,
	output CachePkg::addr_t    missAddr_o,
	// instruction out
	output logic               instrValid_o,
	output CachePkg::instr_t   instr_o,
	output CachePkg::addr_t    pc_o
);

	////////////////////////////////////////////////////////////////////////////
	// stage links
	////////////////////////////////////////////////////////////////////////////

	// tag stage to data array
	logic lookupEnable;
	CachePkg::tag_t lookupTag;
	CachePkg::index_t lookupIndex;
	CachePkg::offset_t lookupOffset;
	logic updateEnable;
	logic updateDeliver;
	CachePkg::line_t updateLine;
	CachePkg::tag_t updateTag;
	CachePkg::index_t updateIndex;
	CachePkg::offset_t updateOffset;

	// data array to aligner
	logic lineEnable;
	CachePkg::tag_t lineTag;
	CachePkg::index_t lineIndex;
	CachePkg::offset_t lineOffset;
	CachePkg::line_t lineData;

	// tag check, miss tracking, refill routing
	TagLookup u_tagLookup
	(
		.clock_i         (clock_i),
		.rstN_i          (rstN_i),
		.flush_i         (flush_i),
		.fetchValid_i    (fetchValid_i),
		.fetchAddr_i     (fetchAddr_i),
		.refillValid_i   (refillValid_i),
		.refillAddr_i    (refillAddr_i),
		.refillLine_i    (refillLine_i),
		.fetchReady_o    (fetchReady_o),
		.missValid_o     (missValid_o),
		.missAddr_o      (missAddr_o),
		.fetchEnable_o   (lookupEnable),
		.tag_o           (lookupTag),
		.index_o         (lookupIndex),
		.offset_o        (lookupOffset),
		.updateEnable_o  (updateEnable),
		.updateDeliver_o (updateDeliver),
		.newLine_o       (updateLine),
		.newTag_o        (updateTag),
		.newIndex_o      (updateIndex),
		.newOffset_o     (updateOffset)
	);

	// line store, two cycle read
	CacheMemory u_cacheMemory
	(
		.clock_i         (clock_i),
		.rstN_i          (rstN_i),
		.flush_i         (flush_i),
		.fetchEnable_i   (lookupEnable),
		.tag_i           (lookupTag),
		.index_i         (lookupIndex),
		.offset_i        (lookupOffset),
		.updateEnable_i  (updateEnable),
		.updateDeliver_i (updateDeliver),
		.newLine_i       (updateLine),
		.newTag_i        (updateTag),
		.newIndex_i      (updateIndex),
		.newOffset_i     (updateOffset),
		.tag_o           (lineTag),
		.index_o         (lineIndex),
		.offset_o        (lineOffset),
		.cacheline_o     (lineData),
		.enable_o        (lineEnable)
	);

	// word pick and output register
	InstructionAlign u_instructionAlign
	(
		.clock_i      (clock_i),
		.rstN_i       (rstN_i),
		.flush_i      (flush_i),
		.enable_i     (lineEnable),
		.tag_i        (lineTag),
		.index_i      (lineIndex),
		.offset_i     (lineOffset),
		.cacheline_i  (lineData),
		.instrValid_o (instrValid_o),
		.instr_o      (instr_o),
		.pc_o         (pc_o)
	);

endmodule

//--- hdl/TagLookup.sv
`timescale 1ns/1ps

module TagLookup
(
	input  logic               clock_i,
	input  logic               rstN_i,
	input  logic               flush_i,
	// fetch request
	input  logic               fetchValid_i,
	input  CachePkg::addr_t    fetchAddr_i,
	// refill from outside
	input  logic               refillValid_i,
	input  CachePkg::addr_t    refillAddr_i,
	input  CachePkg::line_t    refillLine_i,
	// fetch side status
	output logic               fetchReady_o,
	output logic               missValid_o,
	output CachePkg::addr_t    missAddr_o,
	// lookup result towards the data array
	output logic               fetchEnable_o,
	output CachePkg::tag_t     tag_o,
	output CachePkg::index_t   index_o,
	output CachePkg::offset_t  offset_o,
	// update towards the data array
	output logic               updateEnable_o,
	output logic               updateDeliver_o,
	output CachePkg::line_t    newLine_o,
	output CachePkg::tag_t     newTag_o,
	output CachePkg::index_t   newIndex_o,
	output CachePkg::offset_t  newOffset_o
);

	// tag store and valid bits
	CachePkg::tag_t tagArray [CachePkg::numLines];
	logic [CachePkg::numLines-1:0] validBits;

	FetchPkg::lookupState_t state;

	// registered request and its synchronous tag read
	logic reqValid;
	CachePkg::addr_t reqAddr;
	CachePkg::tag_t readTag;
	logic readValid;

	// address fields
	CachePkg::tag_t fetchTag;
	CachePkg::index_t fetchIndex;
	CachePkg::tag_t reqTag;
	CachePkg::index_t reqIndex;
	CachePkg::offset_t reqOffset;
	CachePkg::tag_t refillTag;
	CachePkg::index_t refillIndex;
	CachePkg::index_t lookupIndex;

	logic accept;
	logic tagMatch;
	logic hitNow;
	logic missNow;

	assign fetchTag    = fetchAddr_i[CachePkg::addrWidth-1 -: CachePkg::tagWidth];
	assign fetchIndex  = fetchAddr_i[CachePkg::offsetWidth +: CachePkg::indexWidth];
	assign reqTag      = reqAddr[CachePkg::addrWidth-1 -: CachePkg::tagWidth];
	assign reqIndex    = reqAddr[CachePkg::offsetWidth +: CachePkg::indexWidth];
	assign reqOffset   = reqAddr[CachePkg::offsetWidth-1:0];
	assign refillTag   = refillAddr_i[CachePkg::addrWidth-1 -: CachePkg::tagWidth];
	assign refillIndex = refillAddr_i[CachePkg::offsetWidth +: CachePkg::indexWidth];

	////////////////////////////////////////////////////////////////////////////
	// hit / miss decision
	////////////////////////////////////////////////////////////////////////////

	// a refill owns the data array port for its cycle
	// so the registered request is held and decided one cycle later
	assign tagMatch = readValid && (readTag == reqTag);
	assign hitNow   = reqValid && !refillValid_i && tagMatch;
	assign missNow  = reqValid && !refillValid_i && !tagMatch;

	// no new fetch once a miss is seen, and none while it is pending
	assign fetchReady_o = (state == FetchPkg::LOOKUP) && !missNow && !flush_i;
	assign accept       = fetchValid_i && fetchReady_o && !refillValid_i;

	assign fetchEnable_o = hitNow;
	assign tag_o         = reqTag;
	assign index_o       = reqIndex;
	assign offset_o      = reqOffset;

	// refill routing
	// only a refill that answers a pending miss is forwarded to the output
	assign updateEnable_o  = refillValid_i;
	assign updateDeliver_o = refillValid_i && (state == FetchPkg::MISS_WAIT) && !flush_i;
	assign newLine_o       = refillLine_i;
	assign newTag_o        = refillTag;
	assign newIndex_o      = refillIndex;
	// forwarded word is the one that missed
	assign newOffset_o     = missAddr_o[CachePkg::offsetWidth-1:0];

	// held request re-reads its own index
	assign lookupIndex = accept ? fetchIndex : reqIndex;

	////////////////////////////////////////////////////////////////////////////
	// control state
	////////////////////////////////////////////////////////////////////////////

	always_ff @(posedge clock_i or negedge rstN_i)
	begin
		if (!rstN_i)
		begin
			state       <= FetchPkg::LOOKUP;
			reqValid    <= 1'b0;
			missValid_o <= 1'b0;
			validBits   <= '0;
		end
		else
		begin
			// refill always lands, flush or not
			if (refillValid_i)
				validBits[refillIndex] <= 1'b1;

			if (flush_i)
			begin
				state       <= FetchPkg::LOOKUP;
				reqValid    <= 1'b0;
				missValid_o <= 1'b0;
			end
			else
			begin
				missValid_o <= missNow;
				// a request sitting under a refill stays for another look
				reqValid    <= accept || (reqValid && refillValid_i);
				case (state)
					FetchPkg::LOOKUP:
						if (missNow)
							state <= FetchPkg::MISS_WAIT;
					FetchPkg::MISS_WAIT:
						if (refillValid_i)
							state <= FetchPkg::LOOKUP;
					default:
						state <= FetchPkg::LOOKUP;
				endcase
			end
		end
	end

	////////////////////////////////////////////////////////////////////////////
	// request, miss address and tag array
	////////////////////////////////////////////////////////////////////////////

	always_ff @(posedge clock_i)
	begin
		if (accept)
			reqAddr <= fetchAddr_i;
		if (missNow)
			missAddr_o <= reqAddr;
		if (refillValid_i)
			tagArray[refillIndex] <= refillTag;
		// synchronous tag read, with the same-edge refill forwarded
		if (refillValid_i && (refillIndex == lookupIndex))
		begin
			readTag   <= refillTag;
			readValid <= 1'b1;
		end
		else
		begin
			readTag   <= tagArray[lookupIndex];
			readValid <= validBits[lookupIndex];
		end
	end

endmodule

//--- sim/InstructionCacheTb.sv
`timescale 1ns/1ps

module InstructionCacheTb;

	localparam int randomFetches = 200;
	// directed fetches plus the random run
	localparam int testCount = randomFetches + 13;
	localparam int watchdogCycles = testCount * 12 + 200;
	localparam int poolSize = 8;

	// DUT signals
	logic clock;
	logic rstN;
	logic flush;
	logic fetchValid;
	CachePkg::addr_t fetchAddr;
	logic fetchReady;
	logic refillValid;
	CachePkg::addr_t refillAddr;
	CachePkg::line_t refillLine;
	logic missValid;
	CachePkg::addr_t missAddr;
	logic instrValid;
	CachePkg::instr_t instr;
	CachePkg::addr_t pc;

	integer seed;
	int cycle = 0;
	string testName;
	int valueErrors;
	int protocolErrors;

	// small address pool, pairs of lines share an index
	CachePkg::addr_t poolAddr [poolSize];
	// backing memory, one line per pool entry
	CachePkg::line_t backLine [poolSize];

	// mirror of the tag and valid arrays
	CachePkg::tag_t modelTag [CachePkg::numLines];
	logic [CachePkg::numLines-1:0] modelValid;

	// expected instruction stream, ordered by due cycle
	CachePkg::instr_t expInstr [$];
	CachePkg::addr_t expPc [$];
	int expDue [$];

	// miss and refill tracking
	logic missPending;
	logic missExpected;
	logic missSeen;
	int missDue;
	CachePkg::addr_t missAddrExp;
	CachePkg::instr_t pendInstr;
	CachePkg::addr_t pendPc;
	logic refillPending;
	int refillAt;
	CachePkg::addr_t refillTarget;

	InstructionCache u_dut
	(
		.clock_i       (clock),
		.rstN_i        (rstN),
		.flush_i       (flush),
		.fetchValid_i  (fetchValid),
		.fetchAddr_i   (fetchAddr),
		.fetchReady_o  (fetchReady),
		.refillValid_i (refillValid),
		.refillAddr_i  (refillAddr),
		.refillLine_i  (refillLine),
		.missValid_o   (missValid),
		.missAddr_o    (missAddr),
		.instrValid_o  (instrValid),
		.instr_o       (instr),
		.pc_o          (pc)
	);

	// 20 ns clock
	always #10 clock = ~clock;

	// edge counter, read on the falling edge
	always @(posedge clock)
		cycle <= cycle + 1;

	////////////////////////////////////////////////////////////////////////////
	// helpers
	////////////////////////////////////////////////////////////////////////////

	function automatic int randBelow(input int n);
		randBelow = int'($unsigned($random(seed)) % n);
	endfunction

	function automatic CachePkg::index_t indexOf(input CachePkg::addr_t addr);
		indexOf = addr[CachePkg::offsetWidth +: CachePkg::indexWidth];
	endfunction

	function automatic CachePkg::tag_t tagOf(input CachePkg::addr_t addr);
		tagOf = addr[CachePkg::addrWidth-1 -: CachePkg::tagWidth];
	endfunction

	function automatic CachePkg::addr_t addrIn(input int slot, input CachePkg::offset_t offset);
		addrIn = poolAddr[slot];
		addrIn[CachePkg::offsetWidth-1:0] = offset;
	endfunction

	// backing line that holds this address
	function automatic CachePkg::line_t lineFor(input CachePkg::addr_t addr);
		int i;
		lineFor = '0;
		for (i = 0; i < poolSize; i++)
			if (poolAddr[i][CachePkg::addrWidth-1:CachePkg::offsetWidth] ==
				addr[CachePkg::addrWidth-1:CachePkg::offsetWidth])
				lineFor = backLine[i];
	endfunction

	// little endian, word w sits at bits 32w up to 32w+31
	function automatic CachePkg::instr_t wordOf(input CachePkg::line_t line,
		input CachePkg::addr_t addr);
		wordOf = line[addr[CachePkg::offsetWidth-1:2] * CachePkg::instrWidth
			+: CachePkg::instrWidth];
	endfunction

	task automatic checkInstr(input CachePkg::instr_t expected, input CachePkg::instr_t actual);
		if (actual !== expected)
		begin
			$display("[FAIL] %s instr: expected %h, actual %h", testName, expected, actual);
			valueErrors++;
		end
	endtask

	task automatic checkPc(input CachePkg::addr_t expected, input CachePkg::addr_t actual);
		if (actual !== expected)
		begin
			$display("[FAIL] %s pc: expected %h, actual %h", testName, expected, actual);
			valueErrors++;
		end
	endtask

	task automatic checkMissAddr(input CachePkg::addr_t expected, input CachePkg::addr_t actual);
		if (actual !== expected)
		begin
			$display("[FAIL] %s missAddr: expected %h, actual %h", testName, expected, actual);
			valueErrors++;
		end
	endtask

	task automatic reportError(input string what);
		$display("ERROR %s at cycle %0d: %s", testName, cycle, what);
		protocolErrors++;
	endtask

	task automatic pushExpected(input CachePkg::instr_t word, input CachePkg::addr_t addr,
		input int due);
		expInstr.push_back(word);
		expPc.push_back(addr);
		expDue.push_back(due);
	endtask

	task automatic dropFront();
		void'(expInstr.pop_front());
		void'(expPc.pop_front());
		void'(expDue.pop_front());
	endtask

	////////////////////////////////////////////////////////////////////////////
	// model and stimulus
	////////////////////////////////////////////////////////////////////////////

	task automatic driveRefill();
		CachePkg::index_t idx;
		idx = indexOf(refillTarget);
		refillValid = 1'b1;
		refillAddr = {refillTarget[CachePkg::addrWidth-1:CachePkg::offsetWidth], 5'b0};
		refillLine = lineFor(refillTarget);
		// arrays are written whether or not a miss is still live
		modelTag[idx] = tagOf(refillTarget);
		modelValid[idx] = 1'b1;
		// only a live miss gets its word, two edges after the refill edge
		if (missPending)
		begin
			pushExpected(pendInstr, pendPc, cycle + 3);
			missPending = 1'b0;
		end
		refillPending = 1'b0;
	endtask

	// one cycle: check outputs on the falling edge, then drive the next inputs
	task automatic tick();
		logic expReady;
		@(negedge clock);
		if (instrValid)
		begin
			if (expDue.size() == 0)
				reportError("instrValid_o high with no instruction expected");
			else
			begin
				if (expDue[0] != cycle)
					reportError($sformatf("instruction came at cycle %0d instead of %0d",
						cycle, expDue[0]));
				checkInstr(expInstr[0], instr);
				checkPc(expPc[0], pc);
				dropFront();
			end
		end
		else if (expDue.size() > 0 && expDue[0] <= cycle)
		begin
			reportError("instrValid_o missing for an expected instruction");
			dropFront();
		end
		if (missValid)
		begin
			if (missExpected && missDue == cycle)
				checkMissAddr(missAddrExp, missAddr);
			else
				reportError("missValid_o high with no miss expected");
			missExpected = 1'b0;
			missSeen = 1'b1;
			// refill 2 to 6 cycles after the pulse
			refillPending = 1'b1;
			refillAt = cycle + 1 + randBelow(5);
			refillTarget = missAddr;
		end
		else if (missExpected && missDue <= cycle)
		begin
			reportError("missValid_o missing for an expected miss");
			missExpected = 1'b0;
			missPending = 1'b0;
		end
		expReady = !missPending && !flush;
		if (fetchReady !== expReady)
			reportError($sformatf("fetchReady_o is %b but should be %b", fetchReady, expReady));
		fetchValid = 1'b0;
		refillValid = 1'b0;
		flush = 1'b0;
		if (refillPending && cycle == refillAt)
			driveRefill();
	endtask

	task automatic fetch(input CachePkg::addr_t addr);
		CachePkg::index_t idx;
		CachePkg::instr_t word;
		CachePkg::addr_t alignedPc;
		tick();
		// no fetch while a miss or its refill is outstanding
		while (missPending || refillPending || refillValid)
			tick();
		idx = indexOf(addr);
		word = wordOf(lineFor(addr), addr);
		alignedPc = {addr[CachePkg::addrWidth-1:2], 2'b00};
		fetchValid = 1'b1;
		fetchAddr = addr;
		// accepted at the next edge, a hit shows three edges later
		if (modelValid[idx] && modelTag[idx] == tagOf(addr))
			pushExpected(word, alignedPc, cycle + 4);
		else
		begin
			missPending = 1'b1;
			missExpected = 1'b1;
			missSeen = 1'b0;
			missDue = cycle + 2;
			missAddrExp = addr;
			pendInstr = word;
			pendPc = alignedPc;
		end
	endtask

	task automatic doFlush();
		flush = 1'b1;
		// anything due at the flush edge or later never shows
		while (expDue.size() > 0 && expDue[expDue.size()-1] >= cycle + 1)
		begin
			void'(expInstr.pop_back());
			void'(expPc.pop_back());
			void'(expDue.pop_back());
		end
		if (missExpected && missDue >= cycle + 1)
			missExpected = 1'b0;
		missPending = 1'b0;
	endtask

	task automatic drain();
		tick();
		while (expDue.size() > 0 || missPending || refillPending)
			tick();
	endtask

	////////////////////////////////////////////////////////////////////////////
	// test sequence
	////////////////////////////////////////////////////////////////////////////

	initial
	begin
		int i;
		int w;
		int n;
		seed = 32'h5f05_6cb9;
		clock = 1'b0;
		rstN = 1'b0;
		flush = 1'b0;
		fetchValid = 1'b0;
		fetchAddr = '0;
		refillValid = 1'b0;
		refillAddr = '0;
		refillLine = '0;
		valueErrors = 0;
		protocolErrors = 0;
		missPending = 1'b0;
		missExpected = 1'b0;
		missSeen = 1'b0;
		missDue = 0;
		refillPending = 1'b0;
		refillAt = 0;
		modelValid = '0;
		testName = "reset";
		// indices 0, 3, 6, 9 with two tags each
		for (i = 0; i < poolSize; i++)
		begin
			poolAddr[i] = '0;
			poolAddr[i][CachePkg::addrWidth-1 -: CachePkg::tagWidth] =
				CachePkg::tag_t'(23'h1_5a3c + i % 2);
			poolAddr[i][CachePkg::offsetWidth +: CachePkg::indexWidth] =
				CachePkg::index_t'(3 * (i / 2));
			for (w = 0; w < 8; w++)
				backLine[i][w * CachePkg::instrWidth +: CachePkg::instrWidth] = $random(seed);
		end
		repeat (16) @(negedge clock);
		rstN = 1'b1;
		// idle after reset, ready and quiet
		repeat (4) tick();

		testName = "coldMiss";
		fetch(addrIn(0, 5'h0e));
		drain();

		testName = "hits";
		fetch(addrIn(0, 5'h00));
		fetch(addrIn(0, 5'h1c));
		fetch(addrIn(0, 5'h07));
		fetch(addrIn(0, 5'h13));
		drain();

		// same index, other tag, then back again
		testName = "conflict";
		fetch(addrIn(1, 5'h08));
		drain();
		fetch(addrIn(0, 5'h04));
		drain();

		testName = "flushHits";
		fetch(addrIn(0, 5'h10));
		fetch(addrIn(0, 5'h14));
		fetch(addrIn(0, 5'h18));
		tick();
		doFlush();
		drain();
		fetch(addrIn(0, 5'h0c));
		drain();

		// refill after the flush still fills the line
		testName = "flushMiss";
		fetch(addrIn(2, 5'h10));
		while (!missSeen)
			tick();
		doFlush();
		drain();
		fetch(addrIn(2, 5'h14));
		drain();

		testName = "random";
		n = 0;
		while (n < randomFetches)
		begin
			if (randBelow(4) == 0)
				tick();
			else
			begin
				fetch(addrIn(randBelow(poolSize), CachePkg::offset_t'(randBelow(32))));
				n++;
			end
		end
		drain();
		repeat (4) tick();

		$display("errors: %0d value, %0d protocol, %0d assertion", valueErrors, protocolErrors,
			u_dut.u_assert.failCount);
		if (valueErrors == 0 && protocolErrors == 0 && u_dut.u_assert.failCount == 0)
			$display("TB PASSED");
		else
			$display("TB FAILED");
		$finish;
	end

	// watchdog sized from the number of fetches
	initial
	begin
		repeat (watchdogCycles) @(posedge clock);
		$display("watchdog expired after %0d cycles in %s", watchdogCycles, testName);
		$display("TB FAILED");
		$finish;
	end

endmodule

//--- sim/InstructionCache_assert.sv
`timescale 1ns/1ps

module InstructionCacheAssert
(
	input logic clock_i,
	input logic rstN_i,
	input logic flush_i,
	input logic fetchReady_i,
	input logic missValid_i,
	input logic refillValid_i,
	input logic lookupEnable_i,
	input logic updateDeliver_i
);

	// miss stays open until its refill or a flush
	logic missOpen;

	// failed assertions so far
	int failCount = 0;

	always_ff @(posedge clock_i or negedge rstN_i)
	begin
		if (!rstN_i)
			missOpen <= 1'b0;
		else if (flush_i || refillValid_i)
			missOpen <= 1'b0;
		else if (missValid_i)
			missOpen <= 1'b1;
	end

	// miss report is a one cycle pulse
	missPulse: assert property (@(posedge clock_i) disable iff (!rstN_i)
		missValid_i |=> !missValid_i)
		else
		begin
			$error("missValid_o high for two cycles in a row");
			failCount++;
		end

	// fetches held off while the miss waits for its refill
	missBlocks: assert property (@(posedge clock_i) disable iff (!rstN_i || flush_i)
		(missValid_i || missOpen) && !refillValid_i |-> !fetchReady_i)
		else
		begin
			$error("fetchReady_o high while a miss is pending");
			failCount++;
		end

	// bypass stage of the data array must be empty for a delivered update
	bypassFree: assert property (@(posedge clock_i) disable iff (!rstN_i)
		updateDeliver_i |-> !$past(lookupEnable_i && !flush_i))
		else
		begin
			$error("delivered update while a read sits in the bypass stage");
			failCount++;
		end

endmodule

bind InstructionCache InstructionCacheAssert u_assert
(
	.clock_i         (clock_i),
	.rstN_i          (rstN_i),
	.flush_i         (flush_i),
	.fetchReady_i    (fetchReady_o),
	.missValid_i     (missValid_o),
	.refillValid_i   (refillValid_i),
	.lookupEnable_i  (lookupEnable),
	.updateDeliver_i (updateDeliver)
);
